//--- gpio_consts.svh
// build-time constants of the GPIO block
// host address width, pin count, the address window and the pin masks

`ifndef GPIO_CONSTS_SVH
`define GPIO_CONSTS_SVH

// width of the host address bus
`define GPIO_ABUSWIDTH 16

// number of GPIO pins, a multiple of eight keeps the byte map simple
`define GPIO_IO_WIDTH 16

// address window of the block on the host bus, 16 bytes long
`define GPIO_BASEADDR 16'h1000
`define GPIO_HIGHADDR 16'h100F

// pins that are always driven, whatever the direction byte holds
`define GPIO_IO_DIRECTION 16'h00F0

// pins that are driven only while their direction bit is set
`define GPIO_IO_TRI 16'hFF00

// pins in neither mask are input-only, here the low nibble
// every pin is still visible through the input bytes

`endif

//--- bus_pkg.sv
// types of the host bus side
// address and data vectors, and the local access word that the
// bus front end hands to the register bank

`include "gpio_consts.svh"

package bus_pkg;

    // host address, same width as the bus
    typedef logic [`GPIO_ABUSWIDTH-1:0] bus_addr_t;

    // the host bus moves one byte per access
    typedef logic [7:0] bus_data_t;

    // one local register access, already decoded against the window
    // the strobes are plain levels, each high for a single cycle
    typedef struct packed {
        logic      rd;      // read strobe, only inside the window
        logic      wr;      // write strobe, only inside the window
        bus_addr_t offset;  // address minus the window base
        bus_data_t wdata;   // byte to be written
    } ip_req_t;

endpackage

//--- gpio_pkg.sv
// types of the GPIO side
// pin vector, register offset and the bundle that goes to the pads,
// plus the byte count that sets the register map

`include "gpio_consts.svh"

package gpio_pkg;

    // one bit per pin
    typedef logic [`GPIO_IO_WIDTH-1:0] gpio_vec_t;

    // number of bytes that cover all pins
    // each of input, output and direction takes this many offsets
    localparam int IO_BYTES = ((`GPIO_IO_WIDTH - 1) / 8) + 1;

    // offset into the register map, the window is 16 bytes
    typedef logic [3:0] reg_ofs_t;

    // what the block drives towards the pads
    // a board wrapper turns out and oe into a tri-state buffer per pin
    typedef struct packed {
        gpio_vec_t out;  // output value, zero where the pin is not driven
        gpio_vec_t oe;   // output enable per pin
    } pin_bus_t;

endpackage

//--- bus_to_ip.sv
// host bus front end of the GPIO block
// decodes the address window into local read and write strobes and
// returns the register bank's read byte only for reads that hit

`timescale 1ns/1ps

`include "gpio_consts.svh"

module bus_to_ip
    import bus_pkg::*;
(
    input  logic      BUS_CLK,
    input  logic      RST,
    input  bus_addr_t bus_addr,
    input  bus_data_t bus_wdata,
    input  logic      bus_rd,
    input  logic      bus_wr,
    output bus_data_t bus_rdata,
    output ip_req_t   req,
    input  bus_data_t rdata
);

    localparam bus_addr_t BASE = `GPIO_BASEADDR;
    localparam bus_addr_t HIGH = `GPIO_HIGHADDR;

    logic in_window;
    logic rd_hit_q;   // the last read landed inside the window

    assign in_window = (bus_addr >= BASE) && (bus_addr <= HIGH);

    // local access word, purely combinational from the bus
    always_comb begin
        req.rd     = bus_rd && in_window;
        req.wr     = bus_wr && in_window;
        req.offset = bus_addr - BASE;  // only meaningful while a strobe is high
        req.wdata  = bus_wdata;
    end

    // the flag follows every read, hit or miss, and holds until the next one
    always_ff @(posedge BUS_CLK) begin
        if (RST) begin
            rd_hit_q <= 1'b0;
        end else if (bus_rd) begin
            rd_hit_q <= in_window;
        end
    end

    // Drive zero unless our window was read, so several slaves on a shared
    // bus can simply OR their read bytes together.
    assign bus_rdata = rd_hit_q ? rdata : '0;

    // the host issues either a read or a write in a cycle, never both
    rd_wr_exclusive: assert property (
        @(posedge BUS_CLK) disable iff (RST)
        !(bus_rd && bus_wr)
    );

endmodule

//--- gpio_regs.sv
// register bank of the GPIO block
// output and direction bytes with soft reset, write decode and a
// registered read mux over input, output and direction bytes

`timescale 1ns/1ps

module gpio_regs
    import bus_pkg::*;
    import gpio_pkg::*;
(
    input  logic      BUS_CLK,
    input  logic      RST,
    input  ip_req_t   req,
    output bus_data_t rdata,
    input  gpio_vec_t in_sync,
    output gpio_vec_t out_q,
    output gpio_vec_t dir_q
);

    // register map, each range is IO_BYTES long
    localparam reg_ofs_t OFS_SOFT_RST = '0;
    localparam reg_ofs_t OFS_IN       = reg_ofs_t'(1);
    localparam reg_ofs_t OFS_OUT      = reg_ofs_t'(1 + IO_BYTES);
    localparam reg_ofs_t OFS_DIR      = reg_ofs_t'(1 + 2 * IO_BYTES);

    reg_ofs_t                   ofs;
    logic                       soft_rst;
    bus_data_t [IO_BYTES-1:0]   out_r;     // byte k drives pins 8k..8k+7
    bus_data_t [IO_BYTES-1:0]   dir_r;
    bus_data_t [IO_BYTES-1:0]   in_bytes;
    bus_data_t                  rd_byte;

    // the window is 16 bytes, so the low nibble is the whole offset
    assign ofs = req.offset[3:0];

    // writing anything to offset 0 clears the bank like a bus reset
    assign soft_rst = req.wr && (ofs == OFS_SOFT_RST);

    assign in_bytes = in_sync;

    always_ff @(posedge BUS_CLK) begin
        if (RST || soft_rst) begin
            out_r <= '0;
            dir_r <= '0;
        end else if (req.wr) begin
            // writes to the input range and to unmapped offsets fall through
            for (int k = 0; k < IO_BYTES; k++) begin
                if (ofs == OFS_OUT + reg_ofs_t'(k)) begin
                    out_r[k] <= req.wdata;
                end
                if (ofs == OFS_DIR + reg_ofs_t'(k)) begin
                    dir_r[k] <= req.wdata;
                end
            end
        end
    end

    // read mux, offset 0 and the unmapped tail of the window give zero
    always_comb begin
        rd_byte = '0;
        for (int k = 0; k < IO_BYTES; k++) begin
            if (ofs == OFS_IN + reg_ofs_t'(k)) begin
                rd_byte = in_bytes[k];
            end
            if (ofs == OFS_OUT + reg_ofs_t'(k)) begin
                rd_byte = out_r[k];
            end
            if (ofs == OFS_DIR + reg_ofs_t'(k)) begin
                rd_byte = dir_r[k];
            end
        end
    end

    // the byte is captured at the read edge and holds until the next read
    always_ff @(posedge BUS_CLK) begin
        if (req.rd) begin
            rdata <= rd_byte;
        end
    end

    assign out_q = out_r;
    assign dir_q = dir_r;

    // Register contents only move after a write strobe or a bus reset; a
    // change seen anywhere else would mean a decode fault.
    regs_change_on_write: assert property (
        @(posedge BUS_CLK) disable iff (RST)
        $changed({out_r, dir_r}) |-> $past(req.wr || RST)
    );

endmodule

//--- gpio_pins.sv
// pin stage of the GPIO block
// builds per-pin output values and enables from the register bytes
// and the build-time masks, and synchronizes the pin inputs

`timescale 1ns/1ps

`include "gpio_consts.svh"

module gpio_pins
    import gpio_pkg::*;
(
    input  logic      BUS_CLK,
    input  logic      RST,
    input  gpio_vec_t out_q,
    input  gpio_vec_t dir_q,
    input  gpio_vec_t pin_in,
    output gpio_vec_t in_sync,
    output pin_bus_t  pins
);

    localparam gpio_vec_t DIR_MASK = `GPIO_IO_DIRECTION;  // always driven
    localparam gpio_vec_t TRI_MASK = `GPIO_IO_TRI;        // driven on demand

    gpio_vec_t oe;
    gpio_vec_t sync_q1;  // first synchronizer stage, may go metastable

    // direction bits only count on tri-state pins
    assign oe = DIR_MASK | (TRI_MASK & dir_q);

    assign pins.oe  = oe;
    assign pins.out = out_q & oe;  // undriven pins show zero

    // two flops per pin before the bank may look at the inputs
    always_ff @(posedge BUS_CLK) begin
        if (RST) begin
            sync_q1 <= '0;
            in_sync <= '0;
        end else begin
            sync_q1 <= pin_in;
            in_sync <= sync_q1;
        end
    end

    // input-only pins must never be enabled towards the pads
    oe_inside_masks: assert property (
        @(posedge BUS_CLK) disable iff (RST)
        (pins.oe & ~(DIR_MASK | TRI_MASK)) == '0
    );

endmodule

//--- gpio_top.sv
// top level of the memory-mapped GPIO block
// connects the bus front end, the register bank and the pin stage
// to the host bus and to the pin bundle

`timescale 1ns/1ps

module gpio_top
    import bus_pkg::*;
    import gpio_pkg::*;
(
    input  logic      BUS_CLK,
    input  logic      RST,
    input  bus_addr_t bus_addr,
    input  bus_data_t bus_wdata,
    input  logic      bus_rd,
    input  logic      bus_wr,
    output bus_data_t bus_rdata,
    input  gpio_vec_t pin_in,
    output pin_bus_t  pins
);

    ip_req_t   req;      // decoded local access
    bus_data_t rdata;    // registered read byte from the bank
    gpio_vec_t out_q;
    gpio_vec_t dir_q;
    gpio_vec_t in_sync;  // pin inputs after the synchronizer

    bus_to_ip front_i (
        .BUS_CLK   (BUS_CLK),
        .RST       (RST),
        .bus_addr  (bus_addr),
        .bus_wdata (bus_wdata),
        .bus_rd    (bus_rd),
        .bus_wr    (bus_wr),
        .bus_rdata (bus_rdata),
        .req       (req),
        .rdata     (rdata)
    );

    gpio_regs regs_i (
        .BUS_CLK (BUS_CLK),
        .RST     (RST),
        .req     (req),
        .rdata   (rdata),
        .in_sync (in_sync),
        .out_q   (out_q),
        .dir_q   (dir_q)
    );

    gpio_pins pins_i (
        .BUS_CLK (BUS_CLK),
        .RST     (RST),
        .out_q   (out_q),
        .dir_q   (dir_q),
        .pin_in  (pin_in),
        .in_sync (in_sync),
        .pins    (pins)
    );

endmodule

//--- tb_gpio.sv
// directed testbench of the GPIO block
// clock and reset, bus read and write tasks, compare tasks and the tests
// for reset state, register readback, inputs, soft reset and address decode

`timescale 1ns/1ps

`include "gpio_consts.svh"

module tb_gpio
    import bus_pkg::*;
    import gpio_pkg::*;
();

    localparam bus_addr_t BASE     = `GPIO_BASEADDR;
    localparam bus_addr_t HIGH     = `GPIO_HIGHADDR;
    localparam gpio_vec_t DIR_MASK = `GPIO_IO_DIRECTION;
    localparam gpio_vec_t TRI_MASK = `GPIO_IO_TRI;

    // register map of the block, each range is IO_BYTES long
    localparam int OFS_IN  = 1;
    localparam int OFS_OUT = 1 + IO_BYTES;
    localparam int OFS_DIR = 1 + 2 * IO_BYTES;

    localparam int WINDOW_BYTES = 16;
    localparam int RESET_CYCLES = 16;
    localparam int SYNC_EDGES   = 3;   // two synchronizer flops plus the read edge
    localparam int WAIT_LIMIT   = 32;

    logic      BUS_CLK;
    logic      RST;
    bus_addr_t bus_addr;
    bus_data_t bus_wdata;
    logic      bus_rd;
    logic      bus_wr;
    bus_data_t bus_rdata;
    gpio_vec_t pin_in;
    pin_bus_t  pins;

    integer    seed;
    gpio_vec_t out_model;  // expected output bytes, flattened
    gpio_vec_t dir_model;  // expected direction bytes, flattened

    gpio_top dut_i (
        .BUS_CLK   (BUS_CLK),
        .RST       (RST),
        .bus_addr  (bus_addr),
        .bus_wdata (bus_wdata),
        .bus_rd    (bus_rd),
        .bus_wr    (bus_wr),
        .bus_rdata (bus_rdata),
        .pin_in    (pin_in),
        .pins      (pins)
    );

    always #20 BUS_CLK = ~BUS_CLK;

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("Testbench failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_byte(input bus_data_t got, input bus_data_t exp, input string what);
        if (got !== exp) begin
            stop_run($sformatf("[FAIL] %0t: %s, got %h expected %h", $time, what, got, exp));
        end
    endtask

    task automatic check_pins(input gpio_vec_t got, input gpio_vec_t exp, input string what);
        if (got !== exp) begin
            stop_run($sformatf("[FAIL] %0t: %s, got %h expected %h", $time, what, got, exp));
        end
    endtask

    // counts falling edges, gives up if asked to wait longer than the limit
    task automatic wait_edges(input int edges, input string what);
        int waited;
        waited = 0;
        while (waited < edges) begin
            @(negedge BUS_CLK);
            waited++;
            if (waited > WAIT_LIMIT) begin
                stop_run($sformatf("timeout while waiting for %s", what));
            end
        end
    endtask

    function automatic bus_addr_t reg_addr(input int ofs);
        return BASE + bus_addr_t'(ofs);
    endfunction

    // readback value that the register map predicts for an output or direction offset
    function automatic bus_data_t model_byte(input int ofs);
        if (ofs >= OFS_OUT && ofs < OFS_OUT + IO_BYTES) begin
            return out_model[8*(ofs-OFS_OUT) +: 8];
        end
        if (ofs >= OFS_DIR && ofs < OFS_DIR + IO_BYTES) begin
            return dir_model[8*(ofs-OFS_DIR) +: 8];
        end
        return 8'h00;
    endfunction

    task automatic bus_write(input bus_addr_t addr, input bus_data_t data);
        @(negedge BUS_CLK);
        bus_addr  = addr;
        bus_wdata = data;
        bus_wr    = 1'b1;
        @(negedge BUS_CLK);
        bus_wr    = 1'b0;
    endtask

    // the byte shows on bus_rdata in the cycle after the strobe
    task automatic bus_read(input bus_addr_t addr, output bus_data_t data);
        @(negedge BUS_CLK);
        bus_addr = addr;
        bus_rd   = 1'b1;
        @(negedge BUS_CLK);
        bus_rd   = 1'b0;
        data     = bus_rdata;
    endtask

    // write inside the window and keep the expected register contents in step
    task automatic write_reg(input int ofs, input bus_data_t data);
        bus_write(reg_addr(ofs), data);
        if (ofs == 0) begin
            out_model = '0;
            dir_model = '0;
        end else if (ofs >= OFS_OUT && ofs < OFS_OUT + IO_BYTES) begin
            out_model[8*(ofs-OFS_OUT) +: 8] = data;
        end else if (ofs >= OFS_DIR && ofs < OFS_DIR + IO_BYTES) begin
            dir_model[8*(ofs-OFS_DIR) +: 8] = data;
        end
    endtask

    task automatic read_check(input int ofs, input bus_data_t exp, input string what);
        bus_data_t data;
        bus_read(reg_addr(ofs), data);
        check_byte(data, exp, $sformatf("%s, offset %0d", what, ofs));
    endtask

    task automatic check_regs(input string what);
        for (int ofs = OFS_OUT; ofs < OFS_DIR + IO_BYTES; ofs++) begin
            read_check(ofs, model_byte(ofs), what);
        end
    endtask

    // pin by pin, masked pins are always on and tri-state pins follow their direction bit
    task automatic check_pin_state(input string what);
        gpio_vec_t oe_exp;
        gpio_vec_t out_exp;
        for (int p = 0; p < `GPIO_IO_WIDTH; p++) begin
            if (DIR_MASK[p]) begin
                oe_exp[p] = 1'b1;
            end else if (TRI_MASK[p]) begin
                oe_exp[p] = dir_model[p];
            end else begin
                oe_exp[p] = 1'b0;
            end
            out_exp[p] = oe_exp[p] ? out_model[p] : 1'b0;
        end
        check_pins(pins.oe, oe_exp, {what, ", pin enables"});
        check_pins(pins.out, out_exp, {what, ", pin outputs"});
    endtask

    task automatic test_reset_state();
        check_byte(bus_rdata, 8'h00, "bus_rdata after reset");
        check_pins(pins.out, '0, "pin outputs after reset");
        check_pins(pins.oe, DIR_MASK, "pin enables after reset");
        check_regs("readback after reset");
    endtask

    task automatic test_out_dir();
        for (int round = 0; round < 2; round++) begin
            for (int k = 0; k < IO_BYTES; k++) begin
                write_reg(OFS_OUT + k, bus_data_t'($random(seed)));
                check_pin_state("after output write");
                write_reg(OFS_DIR + k, bus_data_t'($random(seed)));
                check_pin_state("after direction write");
            end
            check_regs("output and direction readback");
        end
    endtask

    task automatic test_input();
        for (int round = 0; round < 3; round++) begin
            @(negedge BUS_CLK);
            pin_in = gpio_vec_t'($random(seed));
            wait_edges(SYNC_EDGES, "input synchronizer");
            for (int k = 0; k < IO_BYTES; k++) begin
                read_check(OFS_IN + k, pin_in[8*k +: 8], "input readback");
            end
        end
    endtask

    task automatic test_soft_reset();
        for (int k = 0; k < IO_BYTES; k++) begin
            write_reg(OFS_OUT + k, bus_data_t'($random(seed)) | 8'h01);
            write_reg(OFS_DIR + k, bus_data_t'($random(seed)) | 8'h80);
        end
        check_pin_state("before soft reset");
        check_regs("readback before soft reset");  // leaves a nonzero byte on bus_rdata
        write_reg(0, bus_data_t'($random(seed)));
        check_pins(pins.out, '0, "pin outputs after soft reset");
        check_pins(pins.oe, DIR_MASK, "pin enables after soft reset");
        read_check(0, 8'h00, "soft reset offset");
        check_regs("readback after soft reset");
    endtask

    task automatic test_decode();
        bus_addr_t outside[6];
        bus_data_t data;
        outside[0] = BASE - bus_addr_t'(1);
        outside[1] = HIGH + bus_addr_t'(1);
        outside[2] = BASE + bus_addr_t'(WINDOW_BYTES + OFS_OUT);  // aliases an output byte
        outside[3] = bus_addr_t'(OFS_DIR);
        outside[4] = '0;  // low nibble of the soft reset offset
        outside[5] = '1;
        for (int k = 0; k < IO_BYTES; k++) begin
            write_reg(OFS_OUT + k, bus_data_t'($random(seed)) | 8'h01);
            write_reg(OFS_DIR + k, bus_data_t'($random(seed)));
        end
        // each miss follows a nonzero hit, so a stale byte would show
        for (int i = 0; i < 6; i++) begin
            read_check(OFS_OUT, model_byte(OFS_OUT), "hit before a miss");
            bus_read(outside[i], data);
            check_byte(data, 8'h00, $sformatf("read outside the window at %h", outside[i]));
        end
        for (int ofs = OFS_DIR + IO_BYTES; ofs < WINDOW_BYTES; ofs++) begin
            read_check(OFS_OUT, model_byte(OFS_OUT), "hit before an unmapped read");
            read_check(ofs, 8'h00, "unmapped offset");
        end
        for (int i = 0; i < 6; i++) begin
            bus_write(outside[i], bus_data_t'($random(seed)));
        end
        for (int ofs = OFS_DIR + IO_BYTES; ofs < WINDOW_BYTES; ofs++) begin
            write_reg(ofs, bus_data_t'($random(seed)));
        end
        for (int ofs = OFS_IN; ofs < OFS_OUT; ofs++) begin
            write_reg(ofs, bus_data_t'($random(seed)));  // input bytes are read-only
        end
        check_pin_state("after ignored writes");
        check_regs("readback after ignored writes");
    endtask

    initial begin
        seed      = 32'h99d9;
        BUS_CLK   = 1'b0;
        RST       = 1'b1;
        bus_addr  = '0;
        bus_wdata = '0;
        bus_rd    = 1'b0;
        bus_wr    = 1'b0;
        pin_in    = '0;
        out_model = '0;
        dir_model = '0;

        wait_edges(RESET_CYCLES, "end of reset");
        RST = 1'b0;

        test_reset_state();
        test_out_dir();
        test_input();
        test_soft_reset();
        test_decode();

        @(negedge BUS_CLK);
        $display("Testbench passed");
        $finish;
    end

endmodule

//--- flist.f
+incdir+.
bus_pkg.sv
gpio_pkg.sv
bus_to_ip.sv
gpio_regs.sv
gpio_pins.sv
gpio_top.sv
tb_gpio.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build the GPIO testbench with Verilator and run it
# the run counts as passed only if the pass line appears in the output

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f flist.f --top-module tb_gpio -o tb_gpio_sim \
    && ./obj_dir/tb_gpio_sim 2>&1 | tee /dev/stderr | grep -qx "Testbench passed" \
    && echo "run_sim: simulation ok" \
    || { echo "run_sim: build or simulation did not succeed"; exit 1; }

exit 0
